//--- apb_leaf_tree_config.svh
`ifndef APB_LEAF_TREE_CONFIG_SVH
`define APB_LEAF_TREE_CONFIG_SVH

// apb bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// cycles the bridge waits for a leaf acknowledge
`define APB_TIMECNT 15

// leaf tree shape
`define LEAF_NUM 3
`define LEAF_REG_NUM 16

// address split
// leaf index sits above the word index
`define LEAF_SEL_LSB 8
`define LEAF_REG_LSB 2

// read data returned when a transfer times out
`define TIMEOUT_RDATA 32'hDEAD_1EAF

`endif

//--- apb_bus_pkg.sv
`default_nettype none

`include "apb_leaf_tree_config.svh"

package apb_bus_pkg;

    // apb side vectors
    typedef logic [`APB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0] data_t;

    // driven by the apb master
    typedef struct packed {
        logic  sel;
        logic  enable;
        logic  write;
        addr_t addr;
        data_t wdata;
    } apb_req_t;

    // returned by the completer
    typedef struct packed {
        logic  ready;
        logic  slverr;
        data_t rdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- leaf_pkg.sv
`default_nettype none

`include "apb_leaf_tree_config.svh"

package leaf_pkg;

    // leaf slot and word within a leaf
    typedef logic [1:0] leaf_idx_t;
    typedef logic [$clog2(`LEAF_REG_NUM)-1:0] reg_idx_t;

    // one-cycle request toward a leaf
    typedef struct packed {
        logic               vld;
        logic               wr_en;
        logic               rd_en;
        apb_bus_pkg::addr_t addr;
        apb_bus_pkg::data_t wr_data;
    } leaf_req_t;

    // ack_vld is a single pulse, rd_data valid with it
    typedef struct packed {
        logic               ack_vld;
        apb_bus_pkg::data_t rd_data;
    } leaf_rsp_t;

endpackage

`default_nettype wire

//--- apb_timeout_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_leaf_tree_config.svh"

module apb_timeout_bridge (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  apb_bus_pkg::apb_req_t apb_req,
    output apb_bus_pkg::apb_rsp_t apb_rsp,
    output leaf_pkg::leaf_req_t   leaf_req,
    input  leaf_pkg::leaf_rsp_t   leaf_rsp,
    output logic                  sync_reset,
    input  logic                  clear,
    output logic                  interrupt,
    output apb_bus_pkg::addr_t    timeout_addr
);
    import apb_bus_pkg::*;

    localparam data_t       ERR_DATA   = `TIMEOUT_RDATA;
    localparam logic [15:0] TIME_LIMIT = 16'(`APB_TIMECNT);

    typedef enum logic {
        st_setup,
        st_wait_ack
    } bridge_state_t;

    bridge_state_t state;
    bridge_state_t next_state;
    logic [15:0]   cnt;
    logic          time_out;
    logic          launch;

    // setup cycle of a new transfer
    assign launch = (state == st_setup) && apb_req.sel && !apb_req.enable;

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state <= st_setup;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_setup: begin
                if (launch) begin
                    next_state = st_wait_ack;
                end
            end
            st_wait_ack: begin
                if (leaf_rsp.ack_vld || time_out) begin
                    next_state = st_setup;
                end
            end
            default: next_state = st_setup;
        endcase
    end

    // request pulse one cycle after setup, payload held until next launch
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            leaf_req <= '0;
        end else begin
            leaf_req.vld   <= launch;
            leaf_req.wr_en <= launch & apb_req.write;
            leaf_req.rd_en <= launch & ~apb_req.write;
            if (launch) begin
                leaf_req.addr    <= apb_req.addr;
                leaf_req.wr_data <= apb_req.wdata;
            end
        end
    end

    // wait counter, strobe lands one cycle after the limit is reached
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            cnt      <= '0;
            time_out <= 1'b0;
        end else begin
            if (state == st_wait_ack && next_state == st_wait_ack) begin
                cnt <= cnt + 16'd1;
            end else begin
                cnt <= '0;
            end
            time_out <= (state == st_wait_ack) && !leaf_rsp.ack_vld &&
                        (cnt == TIME_LIMIT);
        end
    end

    // sticky interrupt and address record, timeout beats clear
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            interrupt    <= 1'b0;
            timeout_addr <= '0;
        end else if (time_out) begin
            interrupt    <= 1'b1;
            timeout_addr <= leaf_req.addr;
        end else if (clear) begin
            interrupt    <= 1'b0;
            timeout_addr <= '0;
        end
    end

    // abort every leaf together with the error response
    assign sync_reset = time_out;

    assign apb_rsp.ready  = leaf_rsp.ack_vld | time_out;
    assign apb_rsp.slverr = time_out;
    assign apb_rsp.rdata  = time_out ? ERR_DATA : leaf_rsp.rd_data;

    // ready lasts a single cycle per transfer
    a_ready_single_pulse: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        apb_rsp.ready |=> !apb_rsp.ready
    ) else $error("ready held for more than one cycle");

    // a leaf must not answer while no transfer is open
    a_no_idle_ready: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        (state == st_setup && !apb_req.sel) |-> !apb_rsp.ready
    ) else $error("ready raised with no apb transfer");

endmodule

`default_nettype wire

//--- leaf_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_leaf_tree_config.svh"

module leaf_decoder (
    input  leaf_pkg::leaf_req_t leaf_req,
    output leaf_pkg::leaf_rsp_t leaf_rsp,
    output leaf_pkg::leaf_req_t leaf_reqs [`LEAF_NUM],
    input  leaf_pkg::leaf_rsp_t leaf_rsps [`LEAF_NUM],
    input  logic                sync_reset,
    output logic [`LEAF_NUM-1:0] leaf_sync_reset
);
    import leaf_pkg::*;

    leaf_idx_t            leaf_idx;
    logic [`LEAF_NUM-1:0] stray_ack;

    assign leaf_idx = leaf_req.addr[`LEAF_SEL_LSB +: $bits(leaf_idx_t)];

    // every leaf sees the payload, only the addressed one gets strobes
    always_comb begin
        for (int i = 0; i < `LEAF_NUM; i++) begin
            leaf_reqs[i] = leaf_req;
            if (leaf_idx != leaf_idx_t'(i)) begin
                leaf_reqs[i].vld   = 1'b0;
                leaf_reqs[i].wr_en = 1'b0;
                leaf_reqs[i].rd_en = 1'b0;
            end
        end
    end

    // unmapped slot answers nothing, bridge will time out
    always_comb begin
        leaf_rsp = '0;
        for (int i = 0; i < `LEAF_NUM; i++) begin
            if (leaf_idx == leaf_idx_t'(i)) begin
                leaf_rsp = leaf_rsps[i];
            end
        end
    end

    // abort fans out to all leaves
    assign leaf_sync_reset = {`LEAF_NUM{sync_reset}};

    // only the addressed leaf may answer, an aborted leaf stays silent
    always_comb begin
        for (int i = 0; i < `LEAF_NUM; i++) begin
            stray_ack[i] = leaf_rsps[i].ack_vld && (leaf_idx != leaf_idx_t'(i));
        end
        a_ack_from_selected: assert (stray_ack == '0)
            else $error("acknowledge from a leaf that was not addressed");
    end

endmodule

`default_nettype wire

//--- leaf_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_leaf_tree_config.svh"

module leaf_reg_bank #(
    parameter int DELAY = 1
) (
    input  logic                PCLK,
    input  logic                PRESETn,
    input  leaf_pkg::leaf_req_t req,
    output leaf_pkg::leaf_rsp_t rsp,
    input  logic                sync_reset
);
    import apb_bus_pkg::*;
    import leaf_pkg::*;

    localparam int               CNT_W    = (DELAY > 1) ? $clog2(DELAY) : 1;
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(DELAY - 1);

    // operation waiting for its acknowledge slot
    typedef struct packed {
        logic     wr;
        logic     rd;
        reg_idx_t idx;
        data_t    data;
    } pend_t;

    data_t            mem [`LEAF_REG_NUM];
    pend_t            pend;
    logic             pend_vld;
    logic [CNT_W-1:0] cnt;
    logic             ack;

    assign ack = pend_vld && (cnt == '0);

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            pend_vld <= 1'b0;
            cnt      <= '0;
        end else if (sync_reset) begin
            // drop whatever is in flight
            pend_vld <= 1'b0;
            cnt      <= '0;
        end else if (req.vld) begin
            pend_vld <= 1'b1;
            cnt      <= CNT_LOAD;
        end else if (ack) begin
            pend_vld <= 1'b0;
        end else if (pend_vld) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge PCLK) begin
        if (req.vld) begin
            pend.wr   <= req.wr_en;
            pend.rd   <= req.rd_en;
            pend.idx  <= req.addr[`LEAF_REG_LSB +: $bits(reg_idx_t)];
            pend.data <= req.wr_data;
        end
    end

    // write lands in the ack cycle unless aborted
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            for (int i = 0; i < `LEAF_REG_NUM; i++) begin
                mem[i] <= '0;
            end
        end else if (ack && pend.wr && !sync_reset) begin
            mem[pend.idx] <= pend.data;
        end
    end

    assign rsp.ack_vld = ack;
    assign rsp.rd_data = (ack && pend.rd) ? mem[pend.idx] : '0;

    // bridge keeps one operation in flight per leaf
    a_no_overlap: assert property (
        @(posedge PCLK) disable iff (!PRESETn)
        req.vld |-> !pend_vld
    ) else $error("leaf request while another is pending");

endmodule

`default_nettype wire

//--- apb_leaf_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_leaf_tree_config.svh"

module apb_leaf_tree (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  apb_bus_pkg::apb_req_t apb_req,
    output apb_bus_pkg::apb_rsp_t apb_rsp,
    input  logic                  clear,
    output logic                  interrupt,
    output apb_bus_pkg::addr_t    timeout_addr
);
    import leaf_pkg::*;

    leaf_req_t            leaf_req;
    leaf_rsp_t            leaf_rsp;
    logic                 sync_reset;
    leaf_req_t            leaf_reqs [`LEAF_NUM];
    leaf_rsp_t            leaf_rsps [`LEAF_NUM];
    logic [`LEAF_NUM-1:0] leaf_sync_reset;

    apb_timeout_bridge u_bridge (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .leaf_req     (leaf_req),
        .leaf_rsp     (leaf_rsp),
        .sync_reset   (sync_reset),
        .clear        (clear),
        .interrupt    (interrupt),
        .timeout_addr (timeout_addr)
    );

    leaf_decoder u_decoder (
        .leaf_req        (leaf_req),
        .leaf_rsp        (leaf_rsp),
        .leaf_reqs       (leaf_reqs),
        .leaf_rsps       (leaf_rsps),
        .sync_reset      (sync_reset),
        .leaf_sync_reset (leaf_sync_reset)
    );

    // fast leaf
    leaf_reg_bank #(.DELAY(1)) u_leaf0 (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .req        (leaf_reqs[0]),
        .rsp        (leaf_rsps[0]),
        .sync_reset (leaf_sync_reset[0])
    );

    leaf_reg_bank #(.DELAY(6)) u_leaf1 (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .req        (leaf_reqs[1]),
        .rsp        (leaf_rsps[1]),
        .sync_reset (leaf_sync_reset[1])
    );

    // slower than the bridge timeout
    leaf_reg_bank #(.DELAY(24)) u_leaf2 (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .req        (leaf_reqs[2]),
        .rsp        (leaf_rsps[2]),
        .sync_reset (leaf_sync_reset[2])
    );

endmodule

`default_nettype wire

//--- apb_leaf_tree_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_leaf_tree_config.svh"

module apb_leaf_tree_tb;
    import apb_bus_pkg::*;
    import leaf_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic     PCLK;
    logic     PRESETn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     clear;
    logic     interrupt;
    addr_t    timeout_addr;

    // expected contents of every leaf
    data_t       model [`LEAF_NUM][`LEAF_REG_NUM];
    logic [31:0] lcg_state;
    string       test_name;
    int          error_count;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          wait_cycles;

    apb_leaf_tree UUT (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .clear        (clear),
        .interrupt    (interrupt),
        .timeout_addr (timeout_addr)
    );

    always #10 PCLK = ~PCLK;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // leaf slot above the word index
    function automatic addr_t make_addr(input leaf_idx_t leaf, input reg_idx_t word);
        addr_t a;
        a = '0;
        a[`LEAF_SEL_LSB +: $bits(leaf_idx_t)] = leaf;
        a[`LEAF_REG_LSB +: $bits(reg_idx_t)]  = word;
        return a;
    endfunction

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s %s expected %b actual %b", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_errors) begin
            $display("%s: passed", test_name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", test_name, error_count - test_errors);
            tests_failed++;
        end
    endtask

    // one apb3 transfer, setup then access until ready
    task automatic run_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic slverr);
        @(posedge PCLK);
        #1;
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        apb_req.write  = write;
        apb_req.addr   = addr;
        apb_req.wdata  = wdata;
        @(posedge PCLK);
        #1;
        apb_req.enable = 1'b1;
        wait_cycles = 0;
        while (!apb_rsp.ready && wait_cycles < WAIT_LIMIT) begin
            @(posedge PCLK);
            #1;
            wait_cycles++;
        end
        if (!apb_rsp.ready) begin
            $display("%s: the DUT gave no ready within %0d cycles for address %h",
                     test_name, WAIT_LIMIT, addr);
            error_count++;
        end
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        @(posedge PCLK);
        #1;
        apb_req.sel    = 1'b0;
        apb_req.enable = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data, output logic slverr);
        data_t unused_rdata;
        run_transfer(1'b1, addr, data, unused_rdata, slverr);
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata, output logic slverr);
        run_transfer(1'b0, addr, '0, rdata, slverr);
    endtask

    // write to a mapped leaf, expected to complete cleanly
    task automatic write_word(input leaf_idx_t leaf, input reg_idx_t word, input data_t data);
        logic slverr;
        apb_write(make_addr(leaf, word), data, slverr);
        check_bit("write slverr", 1'b0, slverr);
        model[leaf][word] = data;
    endtask

    task automatic read_word_checked(input leaf_idx_t leaf, input reg_idx_t word);
        data_t rdata;
        logic  slverr;
        apb_read(make_addr(leaf, word), rdata, slverr);
        check_bit("read slverr", 1'b0, slverr);
        check_data("rdata", model[leaf][word], rdata);
    endtask

    task automatic pulse_clear();
        @(posedge PCLK);
        #1;
        clear = 1'b1;
        @(posedge PCLK);
        #1;
        clear = 1'b0;
    endtask

    task automatic test_reset_values();
        start_test("reset_values");
        check_bit("ready", 1'b0, apb_rsp.ready);
        check_bit("slverr", 1'b0, apb_rsp.slverr);
        check_bit("interrupt", 1'b0, interrupt);
        check_addr("timeout_addr", '0, timeout_addr);
        finish_test();
    endtask

    task automatic test_fast_leaf();
        start_test("fast_leaf");
        for (int w = 0; w < 4; w++) begin
            write_word(2'd0, reg_idx_t'(w), lcg_next());
        end
        for (int w = 0; w < 4; w++) begin
            read_word_checked(2'd0, reg_idx_t'(w));
        end
        // never written
        read_word_checked(2'd0, 4'd9);
        finish_test();
    endtask

    task automatic test_slow_leaf_isolation();
        start_test("slow_leaf_isolation");
        write_word(2'd1, 4'd3, 32'hA5A5_0001);
        write_word(2'd0, 4'd3, 32'h5A5A_0002);
        read_word_checked(2'd1, 4'd3);
        read_word_checked(2'd0, 4'd3);
        read_word_checked(2'd1, 4'd12);
        finish_test();
    endtask

    task automatic test_unmapped_timeout();
        addr_t addr;
        data_t rdata;
        logic  slverr;
        start_test("unmapped_timeout");
        addr = make_addr(2'd3, 4'd5);
        apb_read(addr, rdata, slverr);
        check_bit("slverr", 1'b1, slverr);
        check_data("rdata", `TIMEOUT_RDATA, rdata);
        // setup cycle plus the access cycles
        if (wait_cycles + 1 > `APB_TIMECNT + 3) begin
            $display("%s: the timeout came later than allowed, after %0d cycles",
                     test_name, wait_cycles + 1);
            error_count++;
        end
        check_bit("interrupt", 1'b1, interrupt);
        check_addr("timeout_addr", addr, timeout_addr);
        finish_test();
    endtask

    task automatic test_clear_slow_leaf();
        addr_t addr;
        data_t rdata;
        logic  slverr;
        start_test("clear_slow_leaf");
        pulse_clear();
        check_bit("interrupt after clear", 1'b0, interrupt);
        check_addr("timeout_addr after clear", '0, timeout_addr);
        addr = make_addr(2'd2, 4'd1);
        apb_write(addr, 32'h0BAD_F00D, slverr);
        check_bit("write slverr", 1'b1, slverr);
        check_bit("interrupt", 1'b1, interrupt);
        check_addr("timeout_addr", addr, timeout_addr);
        pulse_clear();
        check_bit("interrupt after clear", 1'b0, interrupt);
        apb_read(addr, rdata, slverr);
        check_bit("read slverr", 1'b1, slverr);
        check_data("rdata", `TIMEOUT_RDATA, rdata);
        check_bit("interrupt", 1'b1, interrupt);
        check_addr("timeout_addr", addr, timeout_addr);
        // aborted leaf 2 work must not disturb this
        read_word_checked(2'd0, 4'd0);
        finish_test();
    endtask

    task automatic test_random_traffic();
        logic [31:0] r;
        leaf_idx_t   leaf;
        reg_idx_t    word;
        start_test("random_traffic");
        for (int i = 0; i < 40; i++) begin
            r    = lcg_next();
            leaf = leaf_idx_t'(r[16]);
            word = r[23:20];
            if (r[28]) begin
                write_word(leaf, word, lcg_next());
            end else begin
                read_word_checked(leaf, word);
            end
        end
        finish_test();
    endtask

    initial begin
        PCLK         = 1'b0;
        PRESETn      = 1'b0;
        apb_req      = '0;
        clear        = 1'b0;
        lcg_state    = 32'd92;
        error_count  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_cycles  = 0;
        test_name    = "init";
        for (int l = 0; l < `LEAF_NUM; l++) begin
            for (int w = 0; w < `LEAF_REG_NUM; w++) begin
                model[l][w] = '0;
            end
        end
        repeat (5) @(posedge PCLK);
        #1;
        PRESETn = 1'b1;

        test_reset_values();
        test_fast_leaf();
        test_slow_leaf_isolation();
        test_unmapped_timeout();
        test_clear_slow_leaf();
        test_random_traffic();

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- apb_leaf_tree.f
+incdir+.
apb_bus_pkg.sv
leaf_pkg.sv
apb_timeout_bridge.sv
leaf_decoder.sv
leaf_reg_bank.sv
apb_leaf_tree.sv
apb_leaf_tree_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the apb leaf tree testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module apb_leaf_tree_tb \
    -f apb_leaf_tree.f -o apb_leaf_tree_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/apb_leaf_tree_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST PASS$" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
